//--- Makefile
# Verilator build and run for the encoder channel testbench

VERILATOR ?= verilator
TOP       ?= enc_channel_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx 'Test OK' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/enc_channel_top.sv
/*
 * encoder channel top
 * filter, decoder, period meter and readout for one quadrature channel
 */
`timescale 1ns/100ps

module enc_channel_top
    import enc_types_pkg::*;
    import enc_regs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      a,                                    // raw encoder lines
    input  logic      b,
    input  logic      rd_en,
    input  reg_addr_t addr,
    output rd_data_t  rd_data
);

    logic     a_filt;
    logic     b_filt;
    logic     edge_stb;
    logic     dir;
    pos_t     position;
    err_cnt_t err_cnt;
    word_t    period;
    word_t    quarter1;
    word_t    quarter5;
    word_t    t_cur;

    // --------------------
    // front end
    // --------------------
    enc_input_filter filt_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .a_filt (a_filt),
        .b_filt (b_filt)
    );

    enc_quad_decoder dec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_filt    (a_filt),
        .b_filt    (b_filt),
        .edge_stb  (edge_stb),
        .edge_kind (),                                      // not mapped in the register space
        .dir       (dir),
        .position  (position),
        .err_cnt   (err_cnt)
    );

    // --------------------
    // measurement and readout
    // --------------------
    enc_period_quad per_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .edge_stb (edge_stb),
        .dir      (dir),
        .period   (period),
        .quarter1 (quarter1),
        .quarter5 (quarter5),
        .t_cur    (t_cur)
    );

    enc_readout rd_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .addr     (addr),
        .position (position),
        .period   (period),
        .quarter1 (quarter1),
        .quarter5 (quarter5),
        .t_cur    (t_cur),
        .err_cnt  (err_cnt),
        .dir      (dir),
        .rd_data  (rd_data)
    );

endmodule

//--- design/enc_input_filter.sv
/*
 * encoder input filter
 * two-flop synchronizer and per-line stability filter for lines a and b
 */
`timescale 1ns/100ps

module enc_input_filter
    import enc_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic a,                                         // raw encoder line a
    input  logic b,                                         // raw encoder line b
    output logic a_filt,
    output logic b_filt
);

    logic [1:0] raw;                                        // [1] = a, [0] = b
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic [1:0] filt;
    filt_cnt_t  stab_cnt [2];                               // samples differing from filt

    assign raw    = {a, b};
    assign a_filt = filt[1];
    assign b_filt = filt[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
            filt  <= '0;
            for (int i = 0; i < 2; i++) begin
                stab_cnt[i] <= '0;
            end
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
            for (int i = 0; i < 2; i++) begin
                if (sync2[i] == filt[i]) begin
                    stab_cnt[i] <= '0;                      // glitch gone, start over
                end else if (stab_cnt[i] == filt_cnt_t'(FILTER_LEN - 1)) begin
                    filt[i]     <= sync2[i];                // FILTER_LEN equal samples seen
                    stab_cnt[i] <= '0;
                end else begin
                    stab_cnt[i] <= stab_cnt[i] + 1'b1;
                end
            end
        end
    end

    // a filtered line only moves after FILTER_LEN synchronized samples at the new level
    for (genvar g = 0; g < 2; g++) begin : g_filt_chk
        for (genvar k = 1; k <= FILTER_LEN; k++) begin : g_win
            filt_settled_a : assert property (@(posedge clk) disable iff (!rst_n)
                $changed(filt[g]) |-> $past(sync2[g], k) == filt[g])
                else $error("line %0d filtered before %0d stable samples", g, FILTER_LEN);
        end
    end

endmodule

//--- design/enc_period_quad.sv
/*
 * encoder period meter
 * counts clock cycles between edge strobes, keeps a queue of quarter counts
 * and reports full period, newest quarter, quarter four edges back and t_cur
 */
`timescale 1ns/100ps

module enc_period_quad
    import enc_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  edge_stb,                                 // from the decoder
    input  logic  dir,
    output word_t period,                                   // [31] ovf, [30] dir, [25:0] cycles
    output word_t quarter1,                                 // [23:0] newest quarter
    output word_t quarter5,                                 // [23:0] quarter four edges back
    output word_t t_cur                                     // [26] queue ovf, [25:0] running
);

    // queue layout
    //   run_cnt    free running count since last edge
    //   qtr_q[1]   newest latched quarter
    //   qtr_q[4]   oldest latched quarter
    cnt_t  run_cnt;
    cnt_t  qtr_q [1:4];

    sum_t  sum4;                                            // running + three newest latched
    logic  sum_sat;
    logic  run_sat;
    logic  latch_ovf;
    word_t period_nxt;

    // clip a counter to the reported quarter width
    function automatic qtr_t clip_qtr(input cnt_t v);
        if (v > cnt_t'(QTR_OVERFLOW)) begin
            return QTR_OVERFLOW;
        end
        return v[QTR_WIDTH-1:0];
    endfunction

    // --------------------
    // combinational view
    // --------------------
    // run_cnt becomes the newest quarter on this edge so it joins the sum
    assign sum4 = sum_t'(run_cnt) + sum_t'(qtr_q[1]) + sum_t'(qtr_q[2]) + sum_t'(qtr_q[3]);
    assign sum_sat = (sum4 > sum_t'(CNT_OVERFLOW));
    assign run_sat = (run_cnt == CNT_OVERFLOW);

    assign latch_ovf = (qtr_q[1] == CNT_OVERFLOW) || (qtr_q[2] == CNT_OVERFLOW) ||
                       (qtr_q[3] == CNT_OVERFLOW) || (qtr_q[4] == CNT_OVERFLOW);

    always_comb begin
        period_nxt = sum_sat ? word_t'(CNT_OVERFLOW) : word_t'(sum4);
        period_nxt[PERIOD_OVF_BIT] = sum_sat | run_sat;
        period_nxt[PERIOD_DIR_BIT] = dir;
    end

    always_comb begin
        t_cur = word_t'(run_cnt);                           // upper bits stay zero
        t_cur[TCUR_OVF_BIT] = latch_ovf;
    end

    // --------------------
    // queue and outputs
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt  <= CNT_OVERFLOW;                       // no measurement yet
            for (int i = 1; i <= 4; i++) begin
                qtr_q[i] <= CNT_OVERFLOW;
            end
            period   <= PERIOD_INIT;
            quarter1 <= '0;
            quarter5 <= '0;
        end else if (edge_stb) begin
            run_cnt  <= cnt_t'(1);                          // the strobe cycle counts as one
            qtr_q[1] <= run_cnt;
            qtr_q[2] <= qtr_q[1];
            qtr_q[3] <= qtr_q[2];
            qtr_q[4] <= qtr_q[3];
            period   <= period_nxt;
            quarter1 <= word_t'(clip_qtr(run_cnt));
            quarter5 <= word_t'(clip_qtr(qtr_q[4]));        // shifted out, four edges old
        end else if (!run_sat) begin
            run_cnt  <= run_cnt + 1'b1;
        end else begin
            period[PERIOD_OVF_BIT] <= 1'b1;                 // encoder too slow, flag it
        end
    end

    // between strobes the running count only climbs and sticks at the limit
    run_no_wrap_a : assert property (@(posedge clk) disable iff (!rst_n)
        !edge_stb |=> run_cnt >= $past(run_cnt))
        else $error("running counter wrapped past CNT_OVERFLOW");

endmodule

//--- design/enc_quad_decoder.sv
/*
 * quadrature decoder
 * turns filtered a/b transitions into position, direction, edge strobe
 * and a saturating count of illegal double transitions
 */
`timescale 1ns/100ps

module enc_quad_decoder
    import enc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       a_filt,
    input  logic       b_filt,
    output logic       edge_stb,                            // one cycle per legal edge
    output edge_kind_t edge_kind,                           // most recent edge
    output logic       dir,                                 // 1 = counting up (b leads)
    output pos_t       position,
    output err_cnt_t   err_cnt
);

    logic [1:0] cur;                                        // {a, b} now
    logic [1:0] prev;                                       // {a, b} one cycle back
    logic [1:0] diff;
    logic       fwd;                                        // step direction of this edge
    edge_kind_t kind;

    assign cur  = {a_filt, b_filt};
    assign diff = cur ^ prev;

    // --------------------
    // edge classification
    // --------------------
    // forward gray order is 00 -> 01 -> 11 -> 10 -> 00
    always_comb begin
        if (diff[1]) begin
            fwd  = (cur[1] == cur[0]);                      // a caught up with b
            kind = cur[1] ? a_up : a_dn;
        end else begin
            fwd  = (cur[1] != cur[0]);                      // b moved away from a
            kind = cur[0] ? b_up : b_dn;
        end
    end

    // --------------------
    // state update
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev      <= '0;
            edge_stb  <= 1'b0;
            edge_kind <= a_up;
            dir       <= 1'b0;
            position  <= '0;
            err_cnt   <= '0;
        end else begin
            prev     <= cur;
            edge_stb <= 1'b0;
            case (diff)
                2'b10, 2'b01: begin                         // single line moved
                    edge_stb  <= 1'b1;
                    edge_kind <= kind;
                    dir       <= fwd;
                    position  <= fwd ? position + pos_t'(1) : position - pos_t'(1);
                end
                2'b11: begin                                // both lines at once, illegal
                    if (err_cnt != '1) begin
                        err_cnt <= err_cnt + 1'b1;
                    end
                end
                default: ;                                  // no change
            endcase
        end
    end

    // the filter window keeps legal edges at least a cycle apart
    stb_single_a : assert property (@(posedge clk) disable iff (!rst_n)
        edge_stb |=> !edge_stb)
        else $error("edge_stb high on two consecutive cycles");

endmodule

//--- design/enc_readout.sv
/*
 * encoder readout
 * registered read mux over the channel measurements, packs the status word
 */
`timescale 1ns/100ps

module enc_readout
    import enc_types_pkg::*;
    import enc_regs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rd_en,                                // read strobe from host side
    input  reg_addr_t addr,
    input  pos_t      position,
    input  word_t     period,
    input  word_t     quarter1,
    input  word_t     quarter5,
    input  word_t     t_cur,
    input  err_cnt_t  err_cnt,
    input  logic      dir,
    output rd_data_t  rd_data                               // valid the cycle after rd_en
);

    rd_data_t status_word;

    // --------------------
    // status packing
    // --------------------
    always_comb begin
        status_word = '0;
        status_word[$bits(err_cnt_t)-1:0] = err_cnt;        // low byte
        status_word[STATUS_DIR_BIT] = dir;
    end

    // --------------------
    // read register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            case (addr)
                ADDR_POSITION: rd_data <= rd_data_t'(position);
                ADDR_PERIOD:   rd_data <= rd_data_t'(period);
                ADDR_QUARTER1: rd_data <= rd_data_t'(quarter1);
                ADDR_QUARTER5: rd_data <= rd_data_t'(quarter5);
                ADDR_TCUR:     rd_data <= rd_data_t'(t_cur);
                ADDR_STATUS:   rd_data <= status_word;
                default:       rd_data <= '0;               // unmapped slots
            endcase
        end
    end

endmodule

//--- design/enc_regs_pkg.sv
/*
 * encoder readout register map
 * addresses and read word of the channel register space
 */
package enc_regs_pkg;

    typedef logic [2:0] reg_addr_t;                         // 8 slots, 6 used
    typedef logic [31:0] rd_data_t;

    // --------------------
    // register addresses
    // --------------------
    localparam reg_addr_t ADDR_POSITION = 3'd0;             // signed position
    localparam reg_addr_t ADDR_PERIOD   = 3'd1;             // full cycle + ovf/dir flags
    localparam reg_addr_t ADDR_QUARTER1 = 3'd2;             // newest quarter
    localparam reg_addr_t ADDR_QUARTER5 = 3'd3;             // quarter four edges back
    localparam reg_addr_t ADDR_TCUR     = 3'd4;             // time since last edge
    localparam reg_addr_t ADDR_STATUS   = 3'd5;             // err count and dir

    // status word layout
    // err_cnt sits in the low byte
    localparam int STATUS_DIR_BIT = 8;

endpackage

//--- design/enc_types_pkg.sv
/*
 * encoder datapath types
 * widths, counter limits and filter length shared by the channel RTL
 */
package enc_types_pkg;

    // --------------------
    // cycle counters
    // --------------------
    localparam int CNT_WIDTH = 26;                          // running and latched counters
    typedef logic [CNT_WIDTH-1:0] cnt_t;
    localparam cnt_t CNT_OVERFLOW = '1;                     // saturated, or no measurement yet

    localparam int SUM_WIDTH = CNT_WIDTH + 2;               // room for four quarters
    typedef logic [SUM_WIDTH-1:0] sum_t;

    localparam int QTR_WIDTH = 24;                          // reported quarter count
    typedef logic [QTR_WIDTH-1:0] qtr_t;
    localparam qtr_t QTR_OVERFLOW = '1;

    // --------------------
    // output words
    // --------------------
    typedef logic signed [31:0] pos_t;                      // signed position count
    typedef logic [31:0] word_t;                            // period / quarter / t_cur word

    localparam int PERIOD_OVF_BIT = 31;                     // sum or running counter saturated
    localparam int PERIOD_DIR_BIT = 30;
    localparam int TCUR_OVF_BIT   = 26;                     // a queue entry still saturated
    localparam word_t PERIOD_INIT = word_t'(CNT_OVERFLOW) | (word_t'(1) << PERIOD_OVF_BIT);

    // edge encoding as seen on the a/b pair
    typedef enum logic [1:0] {
        a_up = 2'b00,
        b_up = 2'b01,
        a_dn = 2'b10,
        b_dn = 2'b11
    } edge_kind_t;

    // input glitch filter
    localparam int FILTER_LEN = 4;                          // stable samples before accept
    localparam int FILT_CNT_WIDTH = $clog2(FILTER_LEN);
    typedef logic [FILT_CNT_WIDTH-1:0] filt_cnt_t;

    typedef logic [7:0] err_cnt_t;                          // illegal transitions, saturating

endpackage

//--- filelist.f
design/enc_types_pkg.sv
design/enc_regs_pkg.sv
design/enc_input_filter.sv
design/enc_quad_decoder.sv
design/enc_period_quad.sv
design/enc_readout.sv
design/enc_channel_top.sv
test/enc_channel_tb.sv

//--- test/enc_channel_tb.sv
/*
 * encoder channel testbench
 * table-driven a/b stimulus with a reference model and register readback
 */
`timescale 1ns/100ps

module enc_channel_tb
    import enc_types_pkg::*;
    import enc_regs_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int UPDATE_LAT   = 2 + FILTER_LEN + 2;       // raw change to period update
    localparam int MIN_HOLD     = 20;                       // leaves room for six reads
    localparam int RANDOM_STEPS = 24;
    localparam logic [5:0] READ_ALL = 6'h3F;                // bit n reads address n

    logic      clk;
    logic      rst_n;
    logic      a;
    logic      b;
    logic      rd_en;
    reg_addr_t addr;
    rd_data_t  rd_data;

    // --------------------
    // stimulus table
    // --------------------
    logic [1:0] tbl_ab     [$];                             // next {a, b}
    int         tbl_hold   [$];                             // cycles until the next entry
    logic [5:0] tbl_read   [$];                             // registers read at the end
    logic [1:0] tbl_glitch [$];                             // lines pulsed for 2 cycles
    longint     total_hold;
    bit         table_ready;
    int         errors;

    // reference model state
    logic [1:0] m_ab;
    pos_t       m_pos;
    logic       m_dir;
    err_cnt_t   m_err;
    cnt_t       m_q [5];                                    // [0] newest quarter
    word_t      m_period;
    bit         m_edge_seen;
    int         m_since;                                    // cycles since last legal change

    enc_channel_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .a       (a),
        .b       (b),
        .rd_en   (rd_en),
        .addr    (addr),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // forward gray order 00 -> 01 -> 11 -> 10
    function automatic logic [1:0] gray_code(input int idx);
        case (idx & 3)
            0:       return 2'b00;
            1:       return 2'b01;
            2:       return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    function automatic int gray_index(input logic [1:0] ab);
        case (ab)
            2'b00:   return 0;
            2'b01:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    task automatic push_step(input logic [1:0] ab, input int hold, input logic [5:0] rd,
                             input logic [1:0] glitch);
        tbl_ab.push_back(ab);
        tbl_hold.push_back(hold);
        tbl_read.push_back(rd);
        tbl_glitch.push_back(glitch);
        total_hold += hold;
    endtask

    task automatic build_table();
        int idx;
        int h;
        int rev_hold [6] = '{20, 33, 27, 41, 22, 30};
        idx = 0;
        push_step(gray_code(idx), MIN_HOLD, 6'h33, 2'b00);  // idle after reset, no quarters yet
        for (int k = 0; k < 7; k++) begin                   // forward, constant hold
            idx++;
            push_step(gray_code(idx), 24, READ_ALL, 2'b00);
        end
        for (int k = 0; k < 6; k++) begin                   // reverse, varying holds
            idx--;
            push_step(gray_code(idx), rev_hold[k], READ_ALL, 2'b00);
        end
        push_step(gray_code(idx), MIN_HOLD, 6'h21, 2'b10);  // short pulse on a
        push_step(gray_code(idx), MIN_HOLD, READ_ALL, 2'b01);
        idx += 2;
        push_step(gray_code(idx), 24, READ_ALL, 2'b00);     // both lines at once
        idx++;
        push_step(gray_code(idx), 26, READ_ALL, 2'b00);
        idx += 2;
        push_step(gray_code(idx), 24, READ_ALL, 2'b00);
        // --------------------
        // random walk
        // --------------------
        for (int k = 0; k < RANDOM_STEPS; k++) begin
            h = MIN_HOLD + int'($urandom % 41);
            if ($urandom % 2 == 1) idx++;
            else idx--;
            push_step(gray_code(idx), h, READ_ALL, 2'b00);
        end
    endtask

    // four newest quarters, saturated, with ovf and dir flags
    function automatic word_t expected_period();
        longint sum;
        word_t  w;
        sum = longint'(m_q[0]) + longint'(m_q[1]) + longint'(m_q[2]) + longint'(m_q[3]);
        if (sum > longint'(CNT_OVERFLOW)) begin
            w = word_t'(CNT_OVERFLOW);
            w[PERIOD_OVF_BIT] = 1'b1;
        end else begin
            w = word_t'(sum);
        end
        w[PERIOD_DIR_BIT] = m_dir;
        return w;
    endfunction

    function automatic word_t saturate_quarter(input cnt_t v);
        if (longint'(v) > longint'(QTR_OVERFLOW)) return word_t'(QTR_OVERFLOW);
        return word_t'(v);
    endfunction

    // running count as sampled by a read issued cyc cycles into the step
    function automatic word_t expected_tcur(input int cyc);
        word_t w;
        if (!m_edge_seen) w = word_t'(CNT_OVERFLOW);
        else w = word_t'(m_since + cyc - UPDATE_LAT + 1);
        w[TCUR_OVF_BIT] = (m_q[0] == CNT_OVERFLOW) || (m_q[1] == CNT_OVERFLOW) ||
                          (m_q[2] == CNT_OVERFLOW) || (m_q[3] == CNT_OVERFLOW);
        return w;
    endfunction

    task automatic update_model(input logic [1:0] ab, output bit legal);
        int step;
        step = (gray_index(ab) - gray_index(m_ab)) & 3;
        legal = (step == 1) || (step == 3);
        if (legal) begin
            m_dir = (step == 1);
            m_pos = m_dir ? m_pos + 1 : m_pos - 1;
            for (int k = 4; k > 0; k--) m_q[k] = m_q[k-1];
            m_q[0] = m_edge_seen ? cnt_t'(m_since) : CNT_OVERFLOW;  // first edge is unmeasured
            m_edge_seen = 1'b1;
            m_since = 0;
            m_period = expected_period();
        end else if (step == 2 && m_err != 8'hFF) begin
            m_err = m_err + 8'd1;
        end
        m_ab = ab;
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_pos(input string name, input pos_t exp, input pos_t got);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_status(input string name, input err_cnt_t exp_err, input logic exp_dir,
                                input rd_data_t got);
        rd_data_t exp;
        exp = '0;
        exp[7:0] = exp_err;
        exp[STATUS_DIR_BIT] = exp_dir;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h got %h", name, exp, got);
        end
    endtask

    // entered on a rising edge, returns on the rising edge two cycles later
    task automatic read_reg(input reg_addr_t ra, output rd_data_t d);
        rd_en <= 1'b1;
        addr  <= ra;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        d = rd_data;                                        // settled, holds until next rd_en
        @(posedge clk);
    endtask

    task automatic apply_step(input int i);
        logic [5:0] rd;
        int         hold;
        int         cyc;
        bit         legal;
        rd_data_t   d;
        hold = tbl_hold[i];
        rd   = tbl_read[i];
        cyc  = 0;
        if (tbl_glitch[i] != 2'b00) begin
            {a, b} <= m_ab ^ tbl_glitch[i];                 // too short for the filter
            repeat (2) @(posedge clk);
            {a, b} <= m_ab;
            cyc = 2;
        end else begin
            {a, b} <= tbl_ab[i];
        end
        update_model(tbl_ab[i], legal);
        repeat (hold - cyc - 2 * $countones(rd)) @(posedge clk);
        cyc = hold - 2 * $countones(rd);
        for (int r = 0; r < 6; r++) begin
            if (rd[r]) begin
                read_reg(reg_addr_t'(r), d);
                case (reg_addr_t'(r))
                    ADDR_POSITION: check_pos($sformatf("position@%0d", i), m_pos, pos_t'(d));
                    ADDR_PERIOD:   check_word($sformatf("period@%0d", i), m_period, d);
                    ADDR_QUARTER1: check_word($sformatf("quarter1@%0d", i),
                                              saturate_quarter(m_q[0]), d);
                    ADDR_QUARTER5: check_word($sformatf("quarter5@%0d", i),
                                              saturate_quarter(m_q[4]), d);
                    ADDR_TCUR: begin
                        check_word($sformatf("t_cur@%0d", i), expected_tcur(cyc), d);
                        if (legal && int'(d[CNT_WIDTH-1:0]) >= hold) begin
                            errors++;
                            $display("Fail t_cur@%0d: expected below %h got %h",
                                     i, hold, d[CNT_WIDTH-1:0]);
                        end
                    end
                    default: check_status($sformatf("status@%0d", i), m_err, m_dir, d);
                endcase
                cyc += 2;
            end
        end
        m_since += hold;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_n = 1'b0;
        a = 1'b0;
        b = 1'b0;
        rd_en = 1'b0;
        addr = '0;
        errors = 0;
        total_hold = 0;
        m_ab = 2'b00;
        m_pos = '0;
        m_dir = 1'b0;
        m_err = '0;
        m_edge_seen = 1'b0;
        m_since = 0;
        for (int k = 0; k < 5; k++) m_q[k] = CNT_OVERFLOW;
        m_period = expected_period();                       // all-overflow queue after reset
        void'($urandom(13660));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < tbl_hold.size(); i++) apply_step(i);
        $display("%0d errors over %0d steps", errors, tbl_hold.size());
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run limit from the table length, with twice the margin
    initial begin
        longint limit;
        wait (table_ready);
        limit = (total_hold + RESET_CYCLES) * 2 * CLK_PERIOD;
        #(limit);
        $display("watchdog expired after %0d ns, the step loop never finished", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule
